// File: hdl/window_raddr_defs.svh
// ============================================================
// window read address generator, shared widths
// address, coordinate and burst length constants used by the
// package and the computing blocks
// ============================================================
`ifndef WINDOW_RADDR_DEFS_SVH
`define WINDOW_RADDR_DEFS_SVH

// ============================================================
// widths
// ============================================================

// row address inside one sram bank
`define WR_AW 10

// picture coordinate and picture size
`define WR_CW 8

// ============================================================
// burst lengths
// ============================================================

// first window of a strip loads the whole 3x3
`define WR_FULL_BEATS 9

// every later move only brings in one new column or row
`define WR_STEP_BEATS 3

`endif

// File: hdl/window_raddr_pkg.sv
// ============================================================
// window read address generator types
// shared typedefs, walk state enum and packed structs
// ============================================================
`include "window_raddr_defs.svh"

package window_raddr_pkg;

    typedef logic [1:0]            bank_t;      // sram bank, 0..2
    typedef logic [`WR_AW-1:0]     row_addr_t;  // address inside a bank
    typedef logic [`WR_CW-1:0]     coord_t;     // picture coord or size
    typedef logic [1:0]            offs_t;      // offset in window, 0..2
    typedef logic [3:0]            tap_t;       // register array tap, 0..8
    typedef logic [2:0]            bitpl_t;     // bit plane

    // snake walk states
    typedef enum logic [2:0] {
        IDLE,
        FULL,   // first window, all 9 taps
        RIGHT,
        DOWN1,
        LEFT,
        DOWN2,
        DONE
    } walk_state_e;

    // picture configuration, held for a whole strip
    typedef struct packed {
        coord_t    pic_size;
        logic      pad_en;
        bitpl_t    bitpl;
        row_addr_t base;
    } win_cfg_s;

    // window origin inside the strip plus walk state
    typedef struct packed {
        logic        x;     // origin column, 0 or 1
        coord_t      y;     // origin row
        walk_state_e state;
    } win_pos_s;

    typedef struct packed {
        offs_t col;
        offs_t row;
    } beat_s;

    // one emitted read address
    typedef struct packed {
        bank_t     bank;
        row_addr_t row;
        logic      pad;     // tap lies outside the picture
        tap_t      tap;
    } raddr_beat_s;

endpackage

// File: hdl/snake_walk_fsm.sv
// ============================================================
// snake walk fsm
// walks the 3x3 window right, down, left, down over one strip,
// counts windows and flags the end of the strip
// ============================================================
`timescale 1ns/1ps
`include "window_raddr_defs.svh"

module snake_walk_fsm
    import window_raddr_pkg::*;
(
    input  logic     SYS_CLK,
    input  logic     SYS_RST,
    input  logic     sop_i,         // start of picture
    input  logic     hsync_i,       // start of next strip
    input  logic     rec_matrix_i,  // register array took a window
    input  logic     busy_i,        // burst still going out
    input  coord_t   pic_size_i,
    output win_pos_s pos_o,
    output logic     burst_go_o,
    output logic     done_o
);

    localparam int CNT_W = `WR_CW + 1;  // 2*(size-2) needs one extra bit

    walk_state_e        state_r;
    walk_state_e        state_nx;
    logic               x_r;
    coord_t             y_r;
    logic [CNT_W-1:0]   win_cnt;
    logic [CNT_W-1:0]   win_last;
    logic               go_r;
    logic               walking;
    logic               start;
    logic               rec_ok;
    logic               last_win;

    // successor in the snake cycle
    function automatic walk_state_e next_move(input walk_state_e s);
        case (s)
            FULL:    return RIGHT;
            RIGHT:   return DOWN1;
            DOWN1:   return LEFT;
            LEFT:    return DOWN2;
            DOWN2:   return RIGHT;
            default: return IDLE;
        endcase
    endfunction

    assign walking  = (state_r != IDLE) && (state_r != DONE);
    assign start    = (sop_i | hsync_i) & ~busy_i & (state_r == IDLE);
    assign rec_ok   = rec_matrix_i & ~busy_i & walking;
    assign win_last = {pic_size_i, 1'b0} - CNT_W'(5);  // window 2*(size-2), 0 based
    assign last_win = rec_ok & (win_cnt == win_last);

    // ============================================================
    // next state
    // ============================================================
    always_comb begin
        state_nx = state_r;
        case (state_r)
            IDLE: begin
                if (start)
                    state_nx = FULL;
            end
            DONE: state_nx = IDLE;             // single cycle
            default: begin
                if (rec_ok)
                    state_nx = last_win ? DONE : next_move(state_r);
            end
        endcase
    end

    // ============================================================
    // state, origin, window count
    // ============================================================
    always_ff @(posedge SYS_CLK or negedge SYS_RST) begin
        if (!SYS_RST) begin
            state_r <= IDLE;
            x_r     <= 1'b0;
            y_r     <= '0;
            win_cnt <= '0;
            go_r    <= 1'b0;
        end else begin
            state_r <= state_nx;
            // burst only on entry to a walk state
            go_r    <= (state_nx != state_r) && (state_nx != DONE) && (state_nx != IDLE);

            if (start)
                win_cnt <= '0;
            else if (rec_ok)
                win_cnt <= win_cnt + 1'b1;

            if (state_nx != state_r) begin
                case (state_nx)
                    FULL: begin
                        x_r <= 1'b0;
                        y_r <= '0;
                    end
                    RIGHT:        x_r <= 1'b1;
                    LEFT:         x_r <= 1'b0;
                    DOWN1, DOWN2: y_r <= y_r + 1'b1;
                    default: ;                 // idle/done keep origin
                endcase
            end
        end
    end

    assign pos_o      = '{x: x_r, y: y_r, state: state_r};
    assign burst_go_o = go_r;
    assign done_o     = (state_r == DONE);

    // done is a pulse, the walk must fall back to idle
    a_done_single: assert property (@(posedge SYS_CLK) disable iff (!SYS_RST)
        (state_r == DONE) |=> (state_r != DONE));

endmodule

// File: hdl/burst_counter.sv
// ============================================================
// burst counter
// sends 9 beats for the first window, 3 for each move, and
// places the column/row offsets per walk direction
// ============================================================
`timescale 1ns/1ps
`include "window_raddr_defs.svh"

module burst_counter
    import window_raddr_pkg::*;
(
    input  logic        SYS_CLK,
    input  logic        SYS_RST,
    input  logic        burst_go_i,
    input  walk_state_e state_i,
    output beat_s       beat_o,
    output logic        beat_vld_o,
    output logic        busy_o
);

    offs_t      lo_r;       // fast counter
    offs_t      hi_r;       // slow counter, full burst only
    logic       busy_r;
    logic       beat_vld;
    logic       last_beat;
    logic [3:0] burst_len;
    logic [3:0] beat_num;

    // first beat goes out together with burst_go
    assign beat_vld  = burst_go_i | busy_r;
    assign burst_len = (state_i == FULL) ? 4'(`WR_FULL_BEATS) : 4'(`WR_STEP_BEATS);
    assign beat_num  = 4'(hi_r) * 4'd3 + 4'(lo_r) + 4'd1;   // 1 based
    assign last_beat = beat_vld & (beat_num == burst_len);

    always_ff @(posedge SYS_CLK or negedge SYS_RST) begin
        if (!SYS_RST) begin
            lo_r   <= '0;
            hi_r   <= '0;
            busy_r <= 1'b0;
        end else if (beat_vld) begin
            if (last_beat) begin
                lo_r   <= '0;   // counters parked at zero for next go
                hi_r   <= '0;
                busy_r <= 1'b0;
            end else begin
                busy_r <= 1'b1;
                if (lo_r == 2'd2) begin
                    lo_r <= '0;
                    hi_r <= hi_r + 1'b1;
                end else begin
                    lo_r <= lo_r + 1'b1;
                end
            end
        end
    end

    // offsets per direction
    always_comb begin
        case (state_i)
            RIGHT:        beat_o = '{col: 2'd2, row: lo_r};  // new right column
            LEFT:         beat_o = '{col: 2'd0, row: lo_r};  // new left column
            DOWN1, DOWN2: beat_o = '{col: lo_r, row: 2'd2};  // new bottom row
            default:      beat_o = '{col: lo_r, row: hi_r};  // full 3x3
        endcase
    end

    assign beat_vld_o = beat_vld;
    assign busy_o     = busy_r;

    a_no_overlap: assert property (@(posedge SYS_CLK) disable iff (!SYS_RST)
        burst_go_i |-> !busy_o);

endmodule

// File: hdl/addr_calc.sv
// ============================================================
// sram address calculation
// bank rotation per strip, row address from window position,
// base and bit plane, plus the padding flag
// ============================================================
`timescale 1ns/1ps
`include "window_raddr_defs.svh"

module addr_calc
    import window_raddr_pkg::*;
(
    input  logic      SYS_CLK,
    input  logic      SYS_RST,
    input  logic      sop_i,
    input  logic      hsync_i,
    input  win_cfg_s  cfg_i,
    input  win_pos_s  pos_i,
    input  beat_s     beat_i,
    input  logic      beat_vld_i,
    output bank_t     bank_o,
    output row_addr_t row_o,
    output logic      pad_o,
    output logic      vld_o
);

    localparam int PW = `WR_CW + 3;  // room for 2*strip+3 and a sign

    bank_t      bank_sel;   // bank of strip column 0/1
    coord_t     strip_r;
    logic [1:0] loc_c;      // local column 0..3
    coord_t     loc_r;      // local row
    bank_t      bank_sum;
    bank_t      bank_nx;
    row_addr_t  row_nx;
    logic       pad_nx;
    logic [PW-1:0] px;
    logic [PW-1:0] py;

    // ============================================================
    // bank selection and strip count
    // ============================================================
    always_ff @(posedge SYS_CLK or negedge SYS_RST) begin
        if (!SYS_RST) begin
            bank_sel <= '0;
            strip_r  <= '0;
        end else if (sop_i) begin
            bank_sel <= '0;
            strip_r  <= '0;
        end else if (hsync_i) begin
            bank_sel <= (bank_sel == 2'd2) ? 2'd0 : bank_sel + 1'b1;  // 0,1,2,0
            strip_r  <= strip_r + 1'b1;
        end
    end

    // ============================================================
    // address arithmetic
    // ============================================================
    assign loc_c    = {1'b0, pos_i.x} + beat_i.col;
    assign loc_r    = pos_i.y + coord_t'(beat_i.row);

    // columns 2/3 sit in the next bank, mod 3
    assign bank_sum = bank_sel + bank_t'(loc_c[1]);
    assign bank_nx  = (bank_sum == 2'd3) ? 2'd0 : bank_sum;

    // 8 bit planes per row, odd column after a full column block
    assign row_nx = cfg_i.base + row_addr_t'(cfg_i.bitpl)
                  + row_addr_t'({loc_r, 3'b000})
                  + (loc_c[0] ? row_addr_t'({cfg_i.pic_size, 3'b000}) : '0);

    // negative wraps high, so one unsigned compare covers both edges
    assign px     = PW'({strip_r, 1'b0}) + PW'(loc_c) - PW'(cfg_i.pad_en);
    assign py     = PW'(loc_r) - PW'(cfg_i.pad_en);
    assign pad_nx = (px >= PW'(cfg_i.pic_size)) | (py >= PW'(cfg_i.pic_size));

    // ============================================================
    // output register
    // ============================================================
    always_ff @(posedge SYS_CLK or negedge SYS_RST) begin
        if (!SYS_RST)
            vld_o <= 1'b0;
        else
            vld_o <= beat_vld_i;
    end

    always_ff @(posedge SYS_CLK) begin
        if (beat_vld_i) begin
            bank_o <= bank_nx;
            row_o  <= row_nx;
            pad_o  <= pad_nx;
        end
    end

    a_bank_range: assert property (@(posedge SYS_CLK) disable iff (!SYS_RST)
        vld_o |-> (bank_o != 2'd3));

endmodule

// File: hdl/tap_lut.sv
// ============================================================
// tap lookup table
// 3x3 table mapping window offsets to register array taps,
// rotated column or row wise as the window moves
// ============================================================
`timescale 1ns/1ps

module tap_lut
    import window_raddr_pkg::*;
(
    input  logic     SYS_CLK,
    input  logic     SYS_RST,
    input  logic     rec_matrix_i,  // accepted window only
    input  win_pos_s pos_i,
    input  beat_s    beat_i,
    output tap_t     tap_o
);

    tap_t tbl [0:2][0:2];   // [row][col]

    // table follows the move that rec_matrix triggers
    always_ff @(posedge SYS_CLK or negedge SYS_RST) begin
        if (!SYS_RST) begin
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    tbl[r][c] <= tap_t'(3 * r + c);
                end
            end
        end else if (pos_i.state == IDLE) begin
            // back to identity, ready for FULL
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    tbl[r][c] <= tap_t'(3 * r + c);
                end
            end
        end else if (rec_matrix_i) begin
            case (pos_i.state)
                FULL, DOWN2: begin      // next is RIGHT, columns left
                    for (int r = 0; r < 3; r++) begin
                        tbl[r][0] <= tbl[r][1];
                        tbl[r][1] <= tbl[r][2];
                        tbl[r][2] <= tbl[r][0];
                    end
                end
                DOWN1: begin            // next is LEFT, columns right
                    for (int r = 0; r < 3; r++) begin
                        tbl[r][0] <= tbl[r][2];
                        tbl[r][1] <= tbl[r][0];
                        tbl[r][2] <= tbl[r][1];
                    end
                end
                RIGHT, LEFT: begin      // next is a DOWN, rows up
                    for (int c = 0; c < 3; c++) begin
                        tbl[0][c] <= tbl[1][c];
                        tbl[1][c] <= tbl[2][c];
                        tbl[2][c] <= tbl[0][c];
                    end
                end
                default: ;
            endcase
        end
    end

    // selected tap, aligned with addr_calc
    always_ff @(posedge SYS_CLK) begin
        tap_o <= tbl[beat_i.row][beat_i.col];
    end

endmodule

// File: hdl/window_raddr_gen.sv
// ============================================================
// window read address generator top
// snake walk, burst counter, address calc and tap table,
// emitting one valid-only read address stream
// ============================================================
`timescale 1ns/1ps

module window_raddr_gen
    import window_raddr_pkg::*;
(
    input  logic        SYS_CLK,
    input  logic        SYS_RST,
    input  logic        sop_i,
    input  logic        hsync_i,
    input  logic        rec_matrix_i,
    input  win_cfg_s    cfg_i,
    output raddr_beat_s raddr_o,
    output logic        raddr_vld_o,
    output logic        done_o
);

    win_pos_s  pos;
    beat_s     beat;
    logic      burst_go;
    logic      busy;
    logic      walk_busy;   // burst_go cycle counts as busy too
    logic      rec_take;
    logic      beat_vld;
    bank_t     bank;
    row_addr_t row;
    logic      pad;
    tap_t      tap;

    assign walk_busy = busy | burst_go;
    assign rec_take  = rec_matrix_i & ~walk_busy;  // same gating as the fsm

    // ============================================================
    // walk and burst
    // ============================================================
    snake_walk_fsm u_snake_walk_fsm (
        .SYS_CLK      (SYS_CLK),
        .SYS_RST      (SYS_RST),
        .sop_i        (sop_i),
        .hsync_i      (hsync_i),
        .rec_matrix_i (rec_matrix_i),
        .busy_i       (walk_busy),
        .pic_size_i   (cfg_i.pic_size),
        .pos_o        (pos),
        .burst_go_o   (burst_go),
        .done_o       (done_o)
    );

    burst_counter u_burst_counter (
        .SYS_CLK    (SYS_CLK),
        .SYS_RST    (SYS_RST),
        .burst_go_i (burst_go),
        .state_i    (pos.state),
        .beat_o     (beat),
        .beat_vld_o (beat_vld),
        .busy_o     (busy)
    );

    // ============================================================
    // address and tap, one cycle each
    // ============================================================
    addr_calc u_addr_calc (
        .SYS_CLK    (SYS_CLK),
        .SYS_RST    (SYS_RST),
        .sop_i      (sop_i),
        .hsync_i    (hsync_i),
        .cfg_i      (cfg_i),
        .pos_i      (pos),
        .beat_i     (beat),
        .beat_vld_i (beat_vld),
        .bank_o     (bank),
        .row_o      (row),
        .pad_o      (pad),
        .vld_o      (raddr_vld_o)
    );

    tap_lut u_tap_lut (
        .SYS_CLK      (SYS_CLK),
        .SYS_RST      (SYS_RST),
        .rec_matrix_i (rec_take),
        .pos_i        (pos),
        .beat_i       (beat),
        .tap_o        (tap)
    );

    assign raddr_o = '{bank: bank, row: row, pad: pad, tap: tap};

endmodule

// File: testbench/window_ref_model.svh
// ============================================================
// window read address reference model
// predicts the snake walk and every emitted read address,
// padding flag and tap from the picture configuration
// ============================================================
`ifndef WINDOW_REF_MODEL_SVH
`define WINDOW_REF_MODEL_SVH

int          m_bank_sel;    // bank of strip columns 0/1
int          m_strip;       // strip number inside the picture
int          m_x;           // window origin column, 0 or 1
int          m_y;           // window origin row
int          m_move;        // 0 full, 1 right, 2 down, 3 left, 4 down
int          m_win;         // windows issued so far in this strip
raddr_beat_s exp_q[$];      // expected beats of the current burst

// one beat from local column/row
function automatic raddr_beat_s predict_beat(win_cfg_s c, int lc, int lr);
    raddr_beat_s b;
    int          row;
    int          px;
    int          py;
    int          size;
    b    = '0;
    size = int'(c.pic_size);
    b.bank = bank_t'((m_bank_sel + lc / 2) % 3);    // cols 2/3 in next bank
    row  = int'(c.base) + int'(c.bitpl) + 8 * lr;
    if (lc % 2 == 1)
        row = row + 8 * size;                         // odd column block
    b.row = row_addr_t'(row);
    px    = 2 * m_strip + lc - int'(c.pad_en);
    py    = lr - int'(c.pad_en);
    b.pad = (px < 0) || (px >= size) || (py < 0) || (py >= size);
    b.tap = tap_t'((lc % 3) + 3 * (lr % 3));
    return b;
endfunction

// fill exp_q with the beats of the current window
function automatic void queue_burst(win_cfg_s c);
    exp_q.delete();
    for (int i = 0; i < 3; i++) begin
        case (m_move)
            0: begin                                  // full 3x3, col fastest
                for (int j = 0; j < 3; j++)
                    exp_q.push_back(predict_beat(c, m_x + j, m_y + i));
            end
            1: exp_q.push_back(predict_beat(c, m_x + 2, m_y + i));   // right column
            3: exp_q.push_back(predict_beat(c, m_x, m_y + i));       // left column
            default: exp_q.push_back(predict_beat(c, m_x + i, m_y + 2));
        endcase
    end
endfunction

function automatic void new_picture();
    m_bank_sel = 0;
    m_strip    = 0;
endfunction

function automatic void next_strip();
    m_bank_sel = (m_bank_sel + 1) % 3;
    m_strip    = m_strip + 1;
endfunction

function automatic void start_walk();
    m_x    = 0;
    m_y    = 0;
    m_move = 0;
    m_win  = 1;
endfunction

// returns 1 when the accepted window was the last of the strip
function automatic bit advance_walk(win_cfg_s c);
    if (m_win == 2 * (int'(c.pic_size) - 2))
        return 1'b1;
    m_move = (m_move == 4) ? 1 : m_move + 1;
    case (m_move)
        1:       m_x = 1;
        3:       m_x = 0;
        default: m_y = m_y + 1;                       // both downs
    endcase
    m_win = m_win + 1;
    return 1'b0;
endfunction

`endif

// File: testbench/tb_window_raddr_gen.sv
// ============================================================
// testbench for the window read address generator
// random pictures walked strip by strip, every beat and done
// pulse compared against the reference model
// ============================================================
`timescale 1ns/1ps

module tb_window_raddr_gen
    import window_raddr_pkg::*;
();

    localparam int WAIT_MAX = 20;   // cycles allowed for any dut event

    logic        SYS_CLK;
    logic        SYS_RST;
    logic        sop;
    logic        hsync;
    logic        rec_matrix;
    win_cfg_s    cfg;
    raddr_beat_s raddr;
    logic        raddr_vld;
    logic        done;
    integer      seed;
    int          val_errs;
    int          proto_errs;
    int          beat_cnt;

    `include "window_ref_model.svh"

    initial begin
        SYS_CLK = 1'b0;
        forever #5 SYS_CLK = ~SYS_CLK;
    end

    window_raddr_gen u_window_raddr_gen (
        .SYS_CLK      (SYS_CLK),
        .SYS_RST      (SYS_RST),
        .sop_i        (sop),
        .hsync_i      (hsync),
        .rec_matrix_i (rec_matrix),
        .cfg_i        (cfg),
        .raddr_o      (raddr),
        .raddr_vld_o  (raddr_vld),
        .done_o       (done)
    );

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic bank_cmp(bank_t got, bank_t exp, int idx);
        if (got !== exp) begin
            $display("ERR %0t: beat %0d bank %0d, expected %0d", $time, idx, got, exp);
            val_errs++;
        end
    endtask

    task automatic row_cmp(row_addr_t got, row_addr_t exp, int idx);
        if (got !== exp) begin
            $display("ERR %0t: beat %0d row %0d, expected %0d", $time, idx, got, exp);
            val_errs++;
        end
    endtask

    task automatic pad_cmp(logic got, logic exp, int idx);
        if (got !== exp) begin
            $display("ERR %0t: beat %0d pad %b, expected %b", $time, idx, got, exp);
            val_errs++;
        end
    endtask

    task automatic tap_cmp(tap_t got, tap_t exp, int idx);
        if (got !== exp) begin
            $display("ERR %0t: beat %0d tap %0d, expected %0d", $time, idx, got, exp);
            val_errs++;
        end
    endtask

    task automatic beat_cmp(raddr_beat_s got, raddr_beat_s exp, int idx);
        bank_cmp(got.bank, exp.bank, idx);
        row_cmp(got.row, exp.row, idx);
        pad_cmp(got.pad, exp.pad, idx);
        tap_cmp(got.tap, exp.tap, idx);
    endtask

    task automatic done_cmp(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("ERR %0t: done_o %b %s, expected %b", $time, got, what, exp);
            val_errs++;
        end
    endtask

    // ============================================================
    // stimulus and response
    // ============================================================
    // one cycle pulse, 0 sop, 1 hsync, 2 rec_matrix
    task automatic pulse_input(int which);
        @(posedge SYS_CLK);
        #1;
        case (which)
            0:       sop = 1'b1;
            1:       hsync = 1'b1;
            default: rec_matrix = 1'b1;
        endcase
        @(posedge SYS_CLK);
        #1;
        sop        = 1'b0;
        hsync      = 1'b0;
        rec_matrix = 1'b0;
    endtask

    // sampled at negedge, outputs are stable there
    task automatic collect_burst();
        int          n;
        int          idx;
        raddr_beat_s want;
        n = 0;
        do begin
            @(negedge SYS_CLK);
            n++;
        end while (!raddr_vld && n < WAIT_MAX);
        if (!raddr_vld) begin
            $display("timeout: no read address came out within %0d cycles", WAIT_MAX);
            proto_errs++;
            return;
        end
        if (n != 2) begin
            $display("ERR %0t: first beat after %0d cycles, expected 2", $time, n);
            val_errs++;
        end
        idx = 0;
        while (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            if (!raddr_vld) begin
                $display("ERR %0t: valid low at beat %0d", $time, idx);
                val_errs++;
            end
            beat_cmp(raddr, want, idx);
            done_cmp(done, 1'b0, "inside a burst");
            idx++;
            @(negedge SYS_CLK);
        end
        if (raddr_vld) begin
            $display("ERR %0t: extra beat after %0d", $time, idx);
            val_errs++;
        end
        beat_cnt += idx;
    endtask

    task automatic expect_done();
        int n;
        n = 0;
        do begin
            @(negedge SYS_CLK);
            n++;
            if (raddr_vld) begin
                $display("ERR %0t: beat after the last window", $time);
                val_errs++;
            end
        end while (!done && n < WAIT_MAX);
        if (!done) begin
            $display("timeout: done_o never pulsed after the last window");
            proto_errs++;
            return;
        end
        if (n != 1) begin
            $display("ERR %0t: done_o after %0d cycles, expected 1", $time, n);
            val_errs++;
        end
        @(negedge SYS_CLK);
        done_cmp(done, 1'b0, "one cycle after the pulse");   // single pulse
    endtask

    // full strip: start pulse then one rec_matrix per window
    task automatic walk_strip(bit first);
        bit last;
        if (first)
            new_picture();
        else
            next_strip();
        start_walk();
        queue_burst(cfg);
        pulse_input(first ? 0 : 1);
        collect_burst();
        last = 1'b0;
        while (!last) begin
            repeat ($unsigned($random(seed)) % 6) @(posedge SYS_CLK);  // random gap
            last = advance_walk(cfg);
            if (!last)
                queue_burst(cfg);
            pulse_input(2);
            if (last)
                expect_done();
            else
                collect_burst();
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        int p;
        int s;
        seed       = 86;
        sop        = 1'b0;
        hsync      = 1'b0;
        rec_matrix = 1'b0;
        cfg        = '0;
        val_errs   = 0;
        proto_errs = 0;
        beat_cnt   = 0;
        SYS_RST    = 1'b0;
        repeat (16) @(posedge SYS_CLK);
        #1;
        SYS_RST = 1'b1;

        for (p = 0; p < 4; p++) begin
            cfg.pic_size = coord_t'(5 + $unsigned($random(seed)) % 8);   // 5..12
            cfg.pad_en   = (p % 2 == 0);                                 // on and off
            cfg.bitpl    = bitpl_t'($random(seed));
            cfg.base     = row_addr_t'($unsigned($random(seed)) % 832);  // 16*12 rows fit
            for (s = 0; s < 4; s++)
                walk_strip(s == 0);                 // banks 0,1,2,0
        end

        repeat (4) @(posedge SYS_CLK);
        $display("errors: value %0d, protocol %0d, beats checked %0d",
                 val_errs, proto_errs, beat_cnt);
        if (val_errs == 0 && proto_errs == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: window_raddr.f
+incdir+hdl
+incdir+testbench
hdl/window_raddr_pkg.sv
hdl/snake_walk_fsm.sv
hdl/burst_counter.sv
hdl/addr_calc.sv
hdl/tap_lut.sv
hdl/window_raddr_gen.sv
testbench/tb_window_raddr_gen.sv

// File: Makefile
# Verilator build and run for the window read address generator

VERILATOR ?= verilator
TOP       ?= tb_window_raddr_gen
FILELIST  ?= window_raddr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	    echo "simulation ended without a result"; exit 1; \
	else \
	    echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
